//--- src.f
source/rp_bus_pkg.sv
source/rp_dsp_pkg.sv
source/sys_bus_if.sv
source/sys_bus_decoder.sv
source/analog_cfg_regs.sv
source/pdm_level_regs.sv
source/linear_calib.sv
source/adc_frontend.sv
source/pdm_modulator.sv
source/rp_analog_top.sv
tb/tb_rp_analog_top.sv

//--- Bender.yml
package:
  name: rp_analog

sources:
  - source/rp_bus_pkg.sv
  - source/rp_dsp_pkg.sv
  - source/sys_bus_if.sv
  - source/sys_bus_decoder.sv
  - source/analog_cfg_regs.sv
  - source/pdm_level_regs.sv
  - source/linear_calib.sv
  - source/adc_frontend.sv
  - source/pdm_modulator.sv
  - source/rp_analog_top.sv
  - target: test
    files:
      - tb/tb_rp_analog_top.sv

//--- tb/tb_rp_analog_top.sv
// Path checks run only in flushed windows after reconfiguration; random data from a fixed seed
`timescale 1ns/100ps

module tb_rp_analog_top
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
();

  // Run limits, about twice the test length
  localparam int MAX_CYCLES = 4000;
  localparam int ACK_LIMIT  = 4;
  localparam int HIST_D     = 4;
  localparam int RUN_LEN    = 200;
  localparam int PDM_WIN    = 256;
  localparam logic [SYS_AW-1:0] PDM_BASE = 1 << REGION_BIT;

  // Signed sample range
  localparam int SMAX = 2**(SAMPLE_W-1) - 1;
  localparam int SMIN = -(2**(SAMPLE_W-1));

  logic                                adc_clk;
  logic                                top_rst;
  logic        [NUM_CH-1:0][ADC_RAW_W-1:0] adc_dat_i;
  dac_sample_t [NUM_CH-1:0]            gen_dat_i;
  adc_sample_t [NUM_CH-1:0]            adc_dat_o;
  dac_code_t   [NUM_CH-1:0]            dac_dat_o;
  logic        [PDM_CH-1:0]            dac_pwm_o;
  logic        [SYS_AW-1:0]            sys_addr_i;
  logic        [SYS_DW-1:0]            sys_wdata_i;
  logic                                sys_wen_i;
  logic                                sys_ren_i;
  logic        [SYS_DW-1:0]            sys_rdata_o;
  logic                                sys_ack_o;

  // Register model
  logic       [NUM_CH-1:0] m_loop;
  cal_mul_t   [NUM_CH-1:0] m_adc_mul;
  cal_sum_t   [NUM_CH-1:0] m_adc_sum;
  cal_mul_t   [NUM_CH-1:0] m_dac_mul;
  cal_sum_t   [NUM_CH-1:0] m_dac_sum;
  pdm_level_t [PDM_CH-1:0] m_level;

  // Input delay lines and expected outputs
  logic        [NUM_CH-1:0][ADC_RAW_W-1:0] raw_hist [HIST_D];
  dac_sample_t [NUM_CH-1:0]                gen_hist [HIST_D];
  adc_sample_t [NUM_CH-1:0]                exp_adc;
  dac_code_t   [NUM_CH-1:0]                exp_dac;

  logic   path_chk = 1'b0;
  integer seed     = 32'h7e10d892;
  int     cycle_cnt = 0;
  int     err_bus = 0;
  int     err_adc = 0;
  int     err_dac = 0;
  int     err_pdm = 0;

  rp_analog_top i_dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .gen_dat_i   (gen_dat_i),
    .adc_dat_o   (adc_dat_o),
    .dac_dat_o   (dac_dat_o),
    .dac_pwm_o   (dac_pwm_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o)
  );

  // 10 ns clock
  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Gain with floor rounding, then offset and clamp
  function automatic int calib_ref(logic signed [SAMPLE_W-1:0] x, logic signed [15:0] mul,
                                   logic signed [SAMPLE_W-1:0] sum);
    int prod;
    int q;
    prod = x * mul;
    q = prod / (1 << CAL_SHIFT);
    if (prod < 0 && q * (1 << CAL_SHIFT) != prod) begin
      q = q - 1;
    end
    q = q + sum;
    if (q > SMAX) begin
      q = SMAX;
    end else if (q < SMIN) begin
      q = SMIN;
    end
    return q;
  endfunction

  // Pins 15:2, inverted offset binary to signed
  function automatic int adc_conv(logic [ADC_RAW_W-1:0] raw);
    logic [SAMPLE_W-1:0] ob;
    ob = raw[ADC_RAW_W-1 -: SAMPLE_W] ^ {1'b0, {(SAMPLE_W-1){1'b1}}};
    if (ob[SAMPLE_W-1]) begin
      return int'(ob) - (1 << SAMPLE_W);
    end
    return int'(ob);
  endfunction

  // Signed sample to DAC pin code
  function automatic dac_code_t dac_code(int s);
    return dac_code_t'(s) ^ {1'b0, {(SAMPLE_W-1){1'b1}}};
  endfunction

  // Register map, write side
  function automatic void model_write(logic [SYS_AW-1:0] a, logic [SYS_DW-1:0] d);
    int o;
    o = a[REGION_BIT-1:0];
    if (a[REGION_BIT]) begin
      if (o >= ADDR_PDM && o < ADDR_PDM + PDM_CH) begin
        m_level[o-ADDR_PDM] = d[7:0];
      end
    end else begin
      if (o == ADDR_LOOP) begin
        m_loop = d[NUM_CH-1:0];
      end
      for (int c = 0; c < NUM_CH; c++) begin
        if (o == ADDR_ADC_MUL + 2*c) m_adc_mul[c] = d[15:0];
        if (o == ADDR_ADC_SUM + 2*c) m_adc_sum[c] = d[SAMPLE_W-1:0];
        if (o == ADDR_DAC_MUL + 2*c) m_dac_mul[c] = d[15:0];
        if (o == ADDR_DAC_SUM + 2*c) m_dac_sum[c] = d[SAMPLE_W-1:0];
      end
    end
  endfunction

  // Register map, readback with sign extension
  function automatic logic [SYS_DW-1:0] model_read(logic [SYS_AW-1:0] a);
    int                o;
    logic [SYS_DW-1:0] r;
    o = a[REGION_BIT-1:0];
    r = '0;
    if (a[REGION_BIT]) begin
      if (o >= ADDR_PDM && o < ADDR_PDM + PDM_CH) begin
        r = SYS_DW'(m_level[o-ADDR_PDM]);
      end
    end else begin
      if (o == ADDR_LOOP) begin
        r = SYS_DW'(m_loop);
      end
      for (int c = 0; c < NUM_CH; c++) begin
        if (o == ADDR_ADC_MUL + 2*c) r = int'(m_adc_mul[c]);
        if (o == ADDR_ADC_SUM + 2*c) r = int'(m_adc_sum[c]);
        if (o == ADDR_DAC_MUL + 2*c) r = int'(m_dac_mul[c]);
        if (o == ADDR_DAC_SUM + 2*c) r = int'(m_dac_sum[c]);
      end
    end
    return r;
  endfunction

  // Write pattern, negative gain for every word
  function automatic logic [SYS_DW-1:0] fill_word(logic [SYS_AW-1:0] a);
    return (32'h9e37_79b9 * (SYS_DW'(a) + 1)) | 32'h0000_8000;
  endfunction

  // Input history, index k is k+1 edges old
  always @(posedge adc_clk) begin
    raw_hist[0] <= adc_dat_i;
    gen_hist[0] <= gen_dat_i;
    for (int k = 1; k < HIST_D; k++) begin
      raw_hist[k] <= raw_hist[k-1];
      gen_hist[k] <= gen_hist[k-1];
    end
  end

  // ADC 3 cycles, loopback 4, DAC 3
  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      if (m_loop[c]) begin
        exp_adc[c] = adc_sample_t'(calib_ref(
          calib_ref(gen_hist[3][c], m_dac_mul[c], m_dac_sum[c]), m_adc_mul[c], m_adc_sum[c]));
      end else begin
        exp_adc[c] = adc_sample_t'(calib_ref(adc_conv(raw_hist[2][c]), m_adc_mul[c],
                                             m_adc_sum[c]));
      end
      exp_dac[c] = dac_code(calib_ref(gen_hist[2][c], m_dac_mul[c], m_dac_sum[c]));
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  for (genvar c = 0; c < NUM_CH; c++) begin : g_chk
    adc_match: assert property (@(posedge adc_clk) disable iff (top_rst || !path_chk)
        adc_dat_o[c] == exp_adc[c])
      else begin
        err_adc++;
        $display("ERROR: adc_dat_o[%0d] expected %h actual %h",
                 c, $sampled(exp_adc[c]), $sampled(adc_dat_o[c]));
      end
    dac_match: assert property (@(posedge adc_clk) disable iff (top_rst || !path_chk)
        dac_dat_o[c] == exp_dac[c])
      else begin
        err_dac++;
        $display("ERROR: dac_dat_o[%0d] expected %h actual %h",
                 c, $sampled(exp_dac[c]), $sampled(dac_dat_o[c]));
      end
  end

  // Ack exactly one cycle after each strobe
  ack_follows: assert property (@(posedge adc_clk) disable iff (top_rst)
      (sys_wen_i || sys_ren_i) |=> sys_ack_o)
    else begin
      err_bus++;
      $display("Bus strobe was not acknowledged one cycle later");
    end
  ack_only: assert property (@(posedge adc_clk) disable iff (top_rst)
      !(sys_wen_i || sys_ren_i) |=> !sys_ack_o)
    else begin
      err_bus++;
      $display("sys_ack_o was high without a strobe in the cycle before");
    end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Random samples once out of reset
  always @(posedge adc_clk) begin
    if (!top_rst) begin
      for (int c = 0; c < NUM_CH; c++) begin
        adc_dat_i[c] <= $random(seed);
        gen_dat_i[c] <= $random(seed);
      end
    end
  end

  task automatic wait_ack(input logic [SYS_AW-1:0] a, output logic ok);
    int n;
    n = 0;
    do begin
      @(posedge adc_clk);
      n++;
    end while (!sys_ack_o && n < ACK_LIMIT);
    ok = sys_ack_o;
    if (!ok) begin
      err_bus++;
      $display("No acknowledge from address %h within %0d cycles", a, ACK_LIMIT);
    end
  endtask

  task automatic bus_write(input logic [SYS_AW-1:0] a, input logic [SYS_DW-1:0] d);
    logic ok;
    @(posedge adc_clk);
    sys_addr_i  <= a;
    sys_wdata_i <= d;
    sys_wen_i   <= 1'b1;
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;
    wait_ack(a, ok);
    model_write(a, d);
  endtask

  task automatic bus_read(input logic [SYS_AW-1:0] a);
    logic              ok;
    logic [SYS_DW-1:0] rd_exp;
    rd_exp = model_read(a);
    @(posedge adc_clk);
    sys_addr_i <= a;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    wait_ack(a, ok);
    if (ok) begin
      assert (sys_rdata_o == rd_exp) else begin
        err_bus++;
        $display("ERROR: sys_rdata_o at address %h expected %h actual %h",
                 a, rd_exp, sys_rdata_o);
      end
    end
  endtask

  task automatic write_defaults();
    bus_write(ADDR_LOOP, '0);
    for (int c = 0; c < NUM_CH; c++) begin
      bus_write(ADDR_ADC_MUL + 2*c, MUL_UNITY);
      bus_write(ADDR_ADC_SUM + 2*c, '0);
      bus_write(ADDR_DAC_MUL + 2*c, MUL_UNITY);
      bus_write(ADDR_DAC_SUM + 2*c, '0);
    end
    for (int p = 0; p < PDM_CH; p++) begin
      bus_write(PDM_BASE + ADDR_PDM + p, '0);
    end
  endtask

  // Flush the pipeline, then check both paths
  task automatic run_paths(input int n);
    repeat (HIST_D + 2) @(posedge adc_clk);
    path_chk <= 1'b1;
    repeat (n) @(posedge adc_clk);
    path_chk <= 1'b0;
  endtask

  // Ones per output over one full accumulator period
  task automatic pdm_window();
    int ones [PDM_CH];
    for (int p = 0; p < PDM_CH; p++) begin
      ones[p] = 0;
    end
    repeat (PDM_WIN) begin
      @(posedge adc_clk);
      for (int p = 0; p < PDM_CH; p++) begin
        ones[p] += dac_pwm_o[p];
      end
    end
    for (int p = 0; p < PDM_CH; p++) begin
      assert (ones[p] == m_level[p]) else begin
        err_pdm++;
        $display("ERROR: dac_pwm_o[%0d] ones expected %h actual %h", p, m_level[p], ones[p]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    gen_dat_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    m_loop      = '0;
    m_adc_mul   = {NUM_CH{MUL_UNITY}};
    m_adc_sum   = '0;
    m_dac_mul   = {NUM_CH{MUL_UNITY}};
    m_dac_sum   = '0;
    m_level     = '0;
    repeat (4) @(posedge adc_clk);
    top_rst <= 1'b0;
    @(posedge adc_clk);

    // Reset state and register reset values
    assert (sys_ack_o == 1'b0) else begin
      err_bus++;
      $display("ERROR: sys_ack_o expected %h actual %h", 1'b0, sys_ack_o);
    end
    assert (dac_pwm_o == '0) else begin
      err_pdm++;
      $display("ERROR: dac_pwm_o expected %h actual %h", 4'h0, dac_pwm_o);
    end
    for (int c = 0; c < NUM_CH; c++) begin
      assert (dac_dat_o[c] == dac_code(0)) else begin
        err_dac++;
        $display("ERROR: dac_dat_o[%0d] expected %h actual %h", c, dac_code(0), dac_dat_o[c]);
      end
    end
    for (int a = 0; a < 2**SYS_AW; a++) begin
      bus_read(a);
    end

    // Write and read back every word, unmapped ones read zero
    for (int a = 0; a < 2**SYS_AW; a++) begin
      bus_write(a, fill_word(a));
    end
    for (int a = 0; a < 2**SYS_AW; a++) begin
      bus_read(a);
    end
    write_defaults();

    // ADC at unity gain, then forced into both rails
    run_paths(RUN_LEN);
    bus_write(ADDR_ADC_MUL, 32'h0000_7fff);
    bus_write(ADDR_ADC_SUM, 32'h0000_1fff);
    bus_write(ADDR_ADC_MUL + 2, 32'h0000_7fff);
    bus_write(ADDR_ADC_SUM + 2, 32'hffff_e000);
    run_paths(RUN_LEN);

    // DAC with 0.5 and -1.5 gains
    bus_write(ADDR_DAC_MUL, 32'h0000_2000);
    bus_write(ADDR_DAC_SUM, 32'h0000_0123);
    bus_write(ADDR_DAC_MUL + 2, 32'hffff_a000);
    bus_write(ADDR_DAC_SUM + 2, 32'hffff_fed4);
    run_paths(RUN_LEN);

    // Loopback on one channel at a time
    bus_write(ADDR_ADC_MUL, 32'h0000_3000);
    bus_write(ADDR_ADC_SUM, 32'h0000_0040);
    bus_write(ADDR_LOOP, 32'h0000_0001);
    run_paths(RUN_LEN);
    bus_write(ADDR_LOOP, 32'h0000_0002);
    run_paths(RUN_LEN);

    // PDM duty cycles
    bus_write(PDM_BASE + ADDR_PDM, 32'd0);
    bus_write(PDM_BASE + ADDR_PDM + 1, 32'd64);
    bus_write(PDM_BASE + ADDR_PDM + 2, 32'd200);
    bus_write(PDM_BASE + ADDR_PDM + 3, 32'd255);
    repeat (2) @(posedge adc_clk);
    pdm_window();

    $display("Errors: bus %0d, adc %0d, dac %0d, pdm %0d", err_bus, err_adc, err_dac, err_pdm);
    if (err_bus + err_adc + err_dac + err_pdm == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Cycle limit
  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles without reaching the end of the tests", cycle_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- source/rp_analog_top.sv
// Single adc_clk domain; ADC and DAC paths are 3 cycles, loopback 4, no back-pressure
`timescale 1ns/100ps

module rp_analog_top
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
(
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // ADC and generator samples
  input  logic        [NUM_CH-1:0][ADC_RAW_W-1:0] adc_dat_i,
  input  dac_sample_t [NUM_CH-1:0]            gen_dat_i,
  // Calibrated ADC samples and DAC pin codes
  output adc_sample_t [NUM_CH-1:0]            adc_dat_o,
  output dac_code_t   [NUM_CH-1:0]            dac_dat_o,
  // PDM outputs
  output logic        [PDM_CH-1:0]            dac_pwm_o,
  // System bus
  input  logic        [SYS_AW-1:0]            sys_addr_i,
  input  logic        [SYS_DW-1:0]            sys_wdata_i,
  input  logic                                sys_wen_i,
  input  logic                                sys_ren_i,
  output logic        [SYS_DW-1:0]            sys_rdata_o,
  output logic                                sys_ack_o
);

  // DAC code for a zero sample
  localparam dac_code_t DAC_ZERO = {1'b0, {($bits(dac_code_t)-1){1'b1}}};

  logic       [NUM_CH-1:0] loop_mask;
  cal_mul_t   [NUM_CH-1:0] adc_mul;
  cal_sum_t   [NUM_CH-1:0] adc_sum;
  cal_mul_t   [NUM_CH-1:0] dac_mul;
  cal_sum_t   [NUM_CH-1:0] dac_sum;
  pdm_level_t [PDM_CH-1:0] pdm_level;

  //////////////////////////////////////////////////
  // System bus and register blocks
  //////////////////////////////////////////////////

  sys_bus_if bus_sys ();
  sys_bus_if cfg_bus ();
  sys_bus_if pdm_bus ();

  // Pins into the bus interface
  assign bus_sys.addr  = sys_addr_i;
  assign bus_sys.wdata = sys_wdata_i;
  assign bus_sys.wen   = sys_wen_i;
  assign bus_sys.ren   = sys_ren_i;
  assign sys_rdata_o   = bus_sys.rdata;
  assign sys_ack_o     = bus_sys.ack;

  sys_bus_decoder i_decoder (
    .bus_s (bus_sys),
    .cfg_m (cfg_bus),
    .pdm_m (pdm_bus)
  );

  // Loopback mask and calibration
  analog_cfg_regs i_cfg_regs (
    .clk_i     (adc_clk),
    .rst_i     (top_rst),
    .bus       (cfg_bus),
    .loop_o    (loop_mask),
    .adc_mul_o (adc_mul),
    .adc_sum_o (adc_sum),
    .dac_mul_o (dac_mul),
    .dac_sum_o (dac_sum)
  );

  pdm_level_regs i_pdm_regs (
    .clk_i   (adc_clk),
    .rst_i   (top_rst),
    .bus     (pdm_bus),
    .level_o (pdm_level)
  );

  //////////////////////////////////////////////////
  // PDM outputs
  //////////////////////////////////////////////////

  pdm_modulator i_pdm (
    .clk_i   (adc_clk),
    .rst_i   (top_rst),
    .level_i (pdm_level),
    .pdm_o   (dac_pwm_o)
  );

  //////////////////////////////////////////////////
  // Analog channels
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch

    adc_sample_t adc_sel;
    dac_sample_t dac_cal;
    dac_code_t   dac_q;

    // Capture and loopback select
    adc_frontend i_adc_fe (
      .clk_i      (adc_clk),
      .rst_i      (top_rst),
      .adc_raw_i  (adc_dat_i[i]),
      .loop_i     (loop_mask[i]),
      .loop_dat_i (dac_cal),
      .dat_o      (adc_sel)
    );

    linear_calib #(
      .SAMPLE_T (adc_sample_t)
    ) i_adc_cal (
      .clk_i (adc_clk),
      .rst_i (top_rst),
      .dat_i (adc_sel),
      .mul_i (adc_mul[i]),
      .sum_i (adc_sum[i]),
      .dat_o (adc_dat_o[i])
    );

    linear_calib #(
      .SAMPLE_T (dac_sample_t)
    ) i_dac_cal (
      .clk_i (adc_clk),
      .rst_i (top_rst),
      .dat_i (gen_dat_i[i]),
      .mul_i (dac_mul[i]),
      .sum_i (dac_sum[i]),
      .dat_o (dac_cal)
    );

    // Output register, signed to inverted offset binary
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        dac_q <= DAC_ZERO;
      end else begin
        dac_q <= {dac_cal[$bits(dac_sample_t)-1], ~dac_cal[$bits(dac_sample_t)-2:0]};
      end
    end

    assign dac_dat_o[i] = dac_q;

  end

endmodule

//--- source/pdm_modulator.sv
// First-order PDM, full 256-cycle range; level 255 gives one zero per period
`timescale 1ns/100ps

module pdm_modulator
  import rp_dsp_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pdm_level_t [PDM_CH-1:0] level_i,
  output logic       [PDM_CH-1:0] pdm_o
);

  // Accumulator plus carry
  localparam int AW = $bits(pdm_level_t);

  pdm_level_t [PDM_CH-1:0] acc_q;
  logic       [AW:0]       sum_c [PDM_CH];

  // Next accumulator value with carry out
  always_comb begin
    for (int i = 0; i < PDM_CH; i++) begin
      sum_c[i] = acc_q[i] + level_i[i];
    end
  end

  // Carry is the pulse density output
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < PDM_CH; i++) begin
        acc_q[i] <= sum_c[i][AW-1:0];
        pdm_o[i] <= sum_c[i][AW];
      end
    end
  end

endmodule

//--- source/adc_frontend.sv
// Capture of a 14-bit ADC on a 16-bit pin bus; loopback select is combinational after capture
`timescale 1ns/100ps

module adc_frontend
  import rp_dsp_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [ADC_RAW_W-1:0] adc_raw_i,
  input  logic                 loop_i,
  input  dac_sample_t          loop_dat_i,
  output adc_sample_t          dat_o
);

  // Lowest pin bit used by the 14-bit converter
  localparam int RAW_LSB = ADC_RAW_W - $bits(adc_sample_t);

  adc_sample_t raw_q;

  // Inverted offset binary to signed, sign bit kept
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      raw_q <= '0;
    end else begin
      raw_q <= {adc_raw_i[ADC_RAW_W-1], ~adc_raw_i[ADC_RAW_W-2:RAW_LSB]};
    end
  end

  // Digital loopback from the calibrated DAC sample
  assign dat_o = loop_i ? adc_sample_t'(loop_dat_i) : raw_q;

endmodule

//--- source/linear_calib.sv
// Two-stage gain/offset with floor rounding and saturation; sample type must be signed
`timescale 1ns/100ps

module linear_calib
  import rp_dsp_pkg::*;
#(
  parameter type SAMPLE_T = adc_sample_t
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  SAMPLE_T  dat_i,
  input  cal_mul_t mul_i,
  input  cal_sum_t sum_i,
  output SAMPLE_T  dat_o
);

  // Sample, product and sum widths
  localparam int DW = $bits(SAMPLE_T);
  localparam int PW = DW + $bits(cal_mul_t);
  localparam int SW = PW - CAL_SHIFT + 1;

  // Limits of the output type
  localparam logic signed [SW-1:0] SAT_MAX = 2**(DW-1) - 1;
  localparam logic signed [SW-1:0] SAT_MIN = -(2**(DW-1));

  logic signed [PW-1:0] prod_q;
  logic signed [SW-1:0] sum_c;

  // Stage 1, full-width product
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      prod_q <= '0;
    end else begin
      prod_q <= dat_i * mul_i;
    end
  end

  // Arithmetic shift floors toward minus infinity
  assign sum_c = SW'(prod_q >>> CAL_SHIFT) + SW'(sum_i);

  // Stage 2, offset and clamp
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      dat_o <= '0;
    end else if (sum_c > SAT_MAX) begin
      dat_o <= SAMPLE_T'(SAT_MAX);
    end else if (sum_c < SAT_MIN) begin
      dat_o <= SAMPLE_T'(SAT_MIN);
    end else begin
      dat_o <= SAMPLE_T'(sum_c);
    end
  end

endmodule

//--- source/pdm_level_regs.sv
// Four 8-bit levels, one word each; upper data bits ignored on write and read as zero
`timescale 1ns/100ps

module pdm_level_regs
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  sys_bus_if.slave                bus,
  output pdm_level_t [PDM_CH-1:0] level_o
);

  logic [REGION_BIT-1:0] ofs;
  logic [SYS_DW-1:0]     rdata_nxt;

  // Word offset inside the PDM region
  assign ofs = bus.addr[REGION_BIT-1:0];

  // Readback, zero for unmapped words
  always_comb begin
    rdata_nxt = '0;
    for (int i = 0; i < PDM_CH; i++) begin
      if (ofs == ADDR_PDM + i) begin
        rdata_nxt = SYS_DW'(level_o[i]);
      end
    end
  end

  // Levels and single-cycle ack
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      bus.ack <= 1'b0;
      level_o <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;
      for (int i = 0; i < PDM_CH; i++) begin
        if (bus.wen && ofs == ADDR_PDM + i) begin
          level_o[i] <= bus.wdata[$bits(pdm_level_t)-1:0];
        end
      end
    end
  end

  // Read data captured with the strobe
  always_ff @(posedge clk_i) begin
    if (bus.ren) begin
      bus.rdata <= rdata_nxt;
    end
  end

endmodule

//--- source/analog_cfg_regs.sv
// Offsets outside the map ack and read zero; gains and offsets read back sign-extended
`timescale 1ns/100ps

module analog_cfg_regs
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  sys_bus_if.slave              bus,
  output logic     [NUM_CH-1:0] loop_o,
  output cal_mul_t [NUM_CH-1:0] adc_mul_o,
  output cal_sum_t [NUM_CH-1:0] adc_sum_o,
  output cal_mul_t [NUM_CH-1:0] dac_mul_o,
  output cal_sum_t [NUM_CH-1:0] dac_sum_o
);

  logic [REGION_BIT-1:0] ofs;
  logic [SYS_DW-1:0]     rdata_nxt;

  // Word offset inside the region
  assign ofs = bus.addr[REGION_BIT-1:0];

  // Readback mux
  always_comb begin
    rdata_nxt = '0;
    if (ofs == ADDR_LOOP) begin
      rdata_nxt = SYS_DW'(loop_o);
    end
    for (int i = 0; i < NUM_CH; i++) begin
      if (ofs == ADDR_ADC_MUL + 2*i) begin
        rdata_nxt = SYS_DW'(signed'(adc_mul_o[i]));
      end
      if (ofs == ADDR_ADC_SUM + 2*i) begin
        rdata_nxt = SYS_DW'(signed'(adc_sum_o[i]));
      end
      if (ofs == ADDR_DAC_MUL + 2*i) begin
        rdata_nxt = SYS_DW'(signed'(dac_mul_o[i]));
      end
      if (ofs == ADDR_DAC_SUM + 2*i) begin
        rdata_nxt = SYS_DW'(signed'(dac_sum_o[i]));
      end
    end
  end

  //////////////////////////////////////////////////
  // Register writes and ack
  //////////////////////////////////////////////////

  // Gains come out of reset at 1.0
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      bus.ack   <= 1'b0;
      loop_o    <= '0;
      adc_mul_o <= {NUM_CH{MUL_UNITY}};
      adc_sum_o <= '0;
      dac_mul_o <= {NUM_CH{MUL_UNITY}};
      dac_sum_o <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;
      if (bus.wen && ofs == ADDR_LOOP) begin
        loop_o <= bus.wdata[NUM_CH-1:0];
      end
      // Channel stride of 2 words
      for (int i = 0; i < NUM_CH; i++) begin
        if (bus.wen && ofs == ADDR_ADC_MUL + 2*i) begin
          adc_mul_o[i] <= bus.wdata[$bits(cal_mul_t)-1:0];
        end
        if (bus.wen && ofs == ADDR_ADC_SUM + 2*i) begin
          adc_sum_o[i] <= bus.wdata[$bits(cal_sum_t)-1:0];
        end
        if (bus.wen && ofs == ADDR_DAC_MUL + 2*i) begin
          dac_mul_o[i] <= bus.wdata[$bits(cal_mul_t)-1:0];
        end
        if (bus.wen && ofs == ADDR_DAC_SUM + 2*i) begin
          dac_sum_o[i] <= bus.wdata[$bits(cal_sum_t)-1:0];
        end
      end
    end
  end

  // Read data captured with the strobe
  always_ff @(posedge clk_i) begin
    if (bus.ren) begin
      bus.rdata <= rdata_nxt;
    end
  end

endmodule

//--- source/sys_bus_decoder.sv
// Combinational two-region split on REGION_BIT; adds no latency to the bus
`timescale 1ns/100ps

module sys_bus_decoder
  import rp_bus_pkg::*;
(
  sys_bus_if.slave  bus_s,
  sys_bus_if.master cfg_m,
  sys_bus_if.master pdm_m
);

  logic sel_pdm;

  // Region select
  assign sel_pdm = bus_s.addr[REGION_BIT];

  //////////////////////////////////////////////////
  // Request fan-out
  //////////////////////////////////////////////////

  // Address and data go to both regions
  assign cfg_m.addr  = bus_s.addr;
  assign cfg_m.wdata = bus_s.wdata;
  assign pdm_m.addr  = bus_s.addr;
  assign pdm_m.wdata = bus_s.wdata;

  // Strobes only reach the addressed region
  assign cfg_m.wen = bus_s.wen & ~sel_pdm;
  assign cfg_m.ren = bus_s.ren & ~sel_pdm;
  assign pdm_m.wen = bus_s.wen &  sel_pdm;
  assign pdm_m.ren = bus_s.ren &  sel_pdm;

  //////////////////////////////////////////////////
  // Response merge
  //////////////////////////////////////////////////

  // At most one region acks at a time
  assign bus_s.ack = cfg_m.ack | pdm_m.ack;

  // Read data from whichever region answers
  always_comb begin
    if (pdm_m.ack) begin
      bus_s.rdata = pdm_m.rdata;
    end else if (cfg_m.ack) begin
      bus_s.rdata = cfg_m.rdata;
    end else begin
      bus_s.rdata = '0;
    end
  end

endmodule

//--- source/sys_bus_if.sv
// One-cycle strobes, ack exactly one clock later; no new strobe before ack
`timescale 1ns/100ps

interface sys_bus_if
  import rp_bus_pkg::*;
();

  // Request side, valid together with a strobe
  logic [SYS_AW-1:0] addr;
  logic [SYS_DW-1:0] wdata;
  logic              wen;
  logic              ren;

  // Response side, rdata valid while ack is high
  logic [SYS_DW-1:0] rdata;
  logic              ack;

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack
  );

endinterface

//--- source/rp_dsp_pkg.sv
// Two 14-bit analog channels and four 8-bit PDM outputs; gains are Q2.14 signed
package rp_dsp_pkg;

  // Channel counts
  localparam int NUM_CH = 2;
  localparam int PDM_CH = 4;

  // ADC pin bus, low 2 bits unused by the 14-bit converter
  localparam int ADC_RAW_W = 16;

  // Common sample width
  localparam int SAMPLE_W = 14;

  // Signed samples on both sides of the converters
  typedef logic signed [SAMPLE_W-1:0] adc_sample_t;
  typedef logic signed [SAMPLE_W-1:0] dac_sample_t;

  // Inverted offset binary code on the DAC pins
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  // Calibration gain and offset
  typedef logic signed [15:0]         cal_mul_t;
  typedef logic signed [SAMPLE_W-1:0] cal_sum_t;

  // Fractional bits of cal_mul_t
  localparam int CAL_SHIFT = 14;

  // PDM level, duty cycle of level/256
  typedef logic [7:0] pdm_level_t;

endpackage

//--- source/rp_bus_pkg.sv
// Word-addressed system bus with two 32-word regions; register values assume 16-bit gains
package rp_bus_pkg;

  // Bus geometry
  localparam int SYS_AW = 6;
  localparam int SYS_DW = 32;

  // Upper address bit picks the region, 0 calibration and 1 PDM
  localparam int REGION_BIT = 5;

  // Calibration region word offsets, channel stride of 2 words
  localparam int ADDR_LOOP    = 0;
  localparam int ADDR_ADC_MUL = 1;
  localparam int ADDR_ADC_SUM = 2;
  localparam int ADDR_DAC_MUL = 5;
  localparam int ADDR_DAC_SUM = 6;

  // PDM region, one word per channel
  localparam int ADDR_PDM = 0;

  // Gain of 1.0 in Q2.14
  localparam logic [15:0] MUL_UNITY = 16'h4000;

endpackage
